// File: src/icmu_pkg.sv
`default_nettype none

package icmu_pkg;

    localparam int NUM_IRQ     = 8;
    localparam int ID_W        = 3;
    localparam int SLICE_W     = 8;
    localparam int AXIL_ADDR_W = 8;
    localparam int AXIL_DATA_W = 32;

    // register map, byte offsets
    localparam logic [AXIL_ADDR_W-1:0] REG_SLICE_BASE = 8'h00;   // 8 words up to 0x1C
    localparam logic [AXIL_ADDR_W-1:0] REG_ENABLE     = 8'h20;
    localparam logic [AXIL_ADDR_W-1:0] REG_STATUS     = 8'h24;

    typedef logic [NUM_IRQ-1:0]   irq_vec_t;
    typedef logic [ID_W-1:0]      irq_id_t;
    typedef logic [SLICE_W-1:0]   slice_t;
    typedef slice_t [NUM_IRQ-1:0] slice_table_t;

    // entry 0 sits in the low byte
    localparam slice_table_t SLICE_DEFAULTS = {
        8'd50, 8'd40, 8'd25, 8'd30, 8'd15, 8'd5, 8'd20, 8'd10
    };

    typedef struct packed {
        logic     active;
        logic     ctx_save;
        irq_id_t  cur_id;
        irq_vec_t pending;
        logic [2:0] spare;     // reads as zero
    } sched_status_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0]   awaddr;
        logic                     awvalid;
        logic [AXIL_DATA_W-1:0]   wdata;
        logic [AXIL_DATA_W/8-1:0] wstrb;
        logic                     wvalid;
        logic                     bready;
    } axil_wr_req_t;

    typedef struct packed {
        logic       awready;
        logic       wready;
        logic [1:0] bresp;
        logic       bvalid;
    } axil_wr_rsp_t;

    typedef struct packed {
        logic [AXIL_ADDR_W-1:0] araddr;
        logic                   arvalid;
        logic                   rready;
    } axil_rd_req_t;

    typedef struct packed {
        logic                   arready;
        logic [AXIL_DATA_W-1:0] rdata;
        logic [1:0]             rresp;
        logic                   rvalid;
    } axil_rd_rsp_t;

endpackage

`default_nettype wire

// File: src/icmu_axil_regs.sv
`timescale 1ns/1ns
`default_nettype none

module icmu_axil_regs (
    input  wire                          i_clk,
    input  wire                          i_rst_n,
    input  wire icmu_pkg::axil_wr_req_t  i_wr_req,
    input  wire icmu_pkg::axil_rd_req_t  i_rd_req,
    input  wire icmu_pkg::sched_status_t i_status,
    output icmu_pkg::axil_wr_rsp_t       o_wr_rsp,
    output icmu_pkg::axil_rd_rsp_t       o_rd_rsp,
    output icmu_pkg::slice_table_t       o_slices,
    output icmu_pkg::irq_vec_t           o_enable
);
    import icmu_pkg::*;

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    slice_table_t           slices;
    irq_vec_t               enable;
    logic                   awready;
    logic                   arready;
    logic                   bvalid;
    logic                   rvalid;
    logic [1:0]             bresp;
    logic [1:0]             rresp;
    logic [AXIL_DATA_W-1:0] rdata;
    logic [AXIL_DATA_W-1:0] rd_word;
    logic                   wr_fire;
    logic                   rd_fire;
    logic                   wr_ok;
    logic                   rd_ok;

    // word aligned and inside the map
    function automatic logic addr_ok(input logic [AXIL_ADDR_W-1:0] addr);
        return (addr[1:0] == 2'b00) && (addr <= REG_STATUS);
    endfunction

    function automatic irq_id_t slice_idx(input logic [AXIL_ADDR_W-1:0] addr);
        logic [AXIL_ADDR_W-1:0] offs;
        offs = addr - REG_SLICE_BASE;
        return offs[ID_W+1:2];
    endfunction

    assign wr_fire = awready && i_wr_req.awvalid && i_wr_req.wvalid;
    assign rd_fire = arready && i_rd_req.arvalid;
    assign wr_ok   = addr_ok(i_wr_req.awaddr);
    assign rd_ok   = addr_ok(i_rd_req.araddr);

    always_comb begin
        rd_word = '0;
        if (!rd_ok) begin
            rd_word = '0;
        end else if (i_rd_req.araddr < REG_ENABLE) begin
            rd_word[SLICE_W-1:0] = slices[slice_idx(i_rd_req.araddr)];
        end else if (i_rd_req.araddr == REG_ENABLE) begin
            rd_word[NUM_IRQ-1:0] = enable;
        end else begin
            rd_word[$bits(sched_status_t)-1:0] = i_status;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            awready <= 1'b0;
            bvalid  <= 1'b0;
            arready <= 1'b0;
            rvalid  <= 1'b0;
            slices  <= SLICE_DEFAULTS;
            enable  <= '1;
        end else begin
            // aw and w taken together, one beat at a time
            awready <= i_wr_req.awvalid && i_wr_req.wvalid && !awready && !bvalid;
            if (wr_fire) begin
                bvalid <= 1'b1;
            end else if (bvalid && i_wr_req.bready) begin
                bvalid <= 1'b0;
            end

            if (wr_fire && wr_ok && (i_wr_req.wstrb == '1)) begin
                if (i_wr_req.awaddr < REG_ENABLE) begin
                    slices[slice_idx(i_wr_req.awaddr)] <= i_wr_req.wdata[SLICE_W-1:0];
                end else if (i_wr_req.awaddr == REG_ENABLE) begin
                    enable <= i_wr_req.wdata[NUM_IRQ-1:0];
                end
                // status is read only
            end

            arready <= i_rd_req.arvalid && !arready && !rvalid;
            if (rd_fire) begin
                rvalid <= 1'b1;
            end else if (rvalid && i_rd_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    // response payload
    always_ff @(posedge i_clk) begin
        if (wr_fire) begin
            bresp <= wr_ok ? RESP_OKAY : RESP_SLVERR;
        end
        if (rd_fire) begin
            rresp <= rd_ok ? RESP_OKAY : RESP_SLVERR;
            rdata <= rd_word;
        end
    end

    assign o_wr_rsp = '{awready: awready, wready: awready, bresp: bresp, bvalid: bvalid};
    assign o_rd_rsp = '{arready: arready, rdata: rdata, rresp: rresp, rvalid: rvalid};
    assign o_slices = slices;
    assign o_enable = enable;

endmodule

`default_nettype wire

// File: src/irq_capture.sv
`timescale 1ns/1ns
`default_nettype none

module irq_capture #(
    parameter int SYNC_STAGES = 2
) (
    input  wire                     i_clk,
    input  wire                     i_rst_n,
    input  wire icmu_pkg::irq_vec_t i_irq,
    input  wire icmu_pkg::irq_vec_t i_enable,
    input  wire icmu_pkg::irq_vec_t i_clear,
    output icmu_pkg::irq_vec_t      o_pending
);
    import icmu_pkg::*;

    irq_vec_t [SYNC_STAGES-1:0] sync_q;
    irq_vec_t                   prev_q;
    irq_vec_t                   rise_q;
    irq_vec_t                   sync_out;

    assign sync_out = sync_q[SYNC_STAGES-1];

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            sync_q    <= '0;
            prev_q    <= '0;
            rise_q    <= '0;
            o_pending <= '0;
        end else begin
            sync_q <= {sync_q[SYNC_STAGES-2:0], i_irq};
            prev_q <= sync_out;
            rise_q <= sync_out & ~prev_q;   // registered edge
            // new edge wins over clear
            o_pending <= (o_pending & ~i_clear) | (rise_q & i_enable);
        end
    end

endmodule

`default_nettype wire

// File: src/rr_arbiter.sv
`timescale 1ns/1ns
`default_nettype none

module rr_arbiter (
    input  wire icmu_pkg::irq_vec_t i_pending,
    input  wire icmu_pkg::irq_id_t  i_current,
    output icmu_pkg::irq_id_t       o_next,
    output logic                    o_valid
);
    import icmu_pkg::*;

    assign o_valid = |i_pending;

    // walk from farthest to nearest so the nearest hit is kept
    always_comb begin
        irq_id_t idx;
        o_next = i_current;
        for (int i = NUM_IRQ; i >= 1; i--) begin
            idx = i_current + irq_id_t'(i);   // i == NUM_IRQ lands on current
            if (i_pending[idx]) begin
                o_next = idx;
            end
        end
    end

endmodule

`default_nettype wire

// File: src/slice_scheduler.sv
`timescale 1ns/1ns
`default_nettype none

module slice_scheduler (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire                         i_tick_1ms,
    input  wire icmu_pkg::slice_table_t i_slices,
    input  wire icmu_pkg::irq_id_t      i_next,
    input  wire                         i_next_valid,
    input  wire                         i_ctx_saved,
    input  wire                         i_int_done,
    output icmu_pkg::irq_vec_t          o_clear,
    output icmu_pkg::irq_id_t           o_int_id,
    output logic                        o_int_active,
    output logic                        o_ctx_save,
    output icmu_pkg::sched_status_t     o_status
);
    import icmu_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_RUN,
        ST_SAVE
    } state_t;

    state_t           state;
    slice_t           elapsed;
    slice_t           cur_slice;
    logic [SLICE_W:0] elapsed_inc;
    logic             expire;
    logic             take;

    assign cur_slice   = i_slices[o_int_id];
    assign elapsed_inc = {1'b0, elapsed} + 1'b1;

    // zero slice means run to completion
    assign expire = (cur_slice != '0) && (elapsed_inc >= {1'b0, cur_slice});

    // a source is taken on dispatch from idle or on save completion
    assign take = i_next_valid &&
                  ((state == ST_IDLE) || ((state == ST_SAVE) && i_ctx_saved));

    always_comb begin
        o_clear = '0;
        if (take) begin
            o_clear[i_next] = 1'b1;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= ST_IDLE;
            o_int_id <= '0;
            elapsed  <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (take) begin
                        state    <= ST_RUN;
                        o_int_id <= i_next;
                        elapsed  <= '0;
                    end
                end

                ST_RUN: begin
                    if (i_int_done) begin
                        state <= ST_IDLE;
                    end else if (i_tick_1ms) begin
                        elapsed <= elapsed_inc[SLICE_W-1:0];
                        if (expire) begin
                            state <= ST_SAVE;   // ask cpu to save context
                        end
                    end
                end

                // elapsed and id frozen, done ignored
                ST_SAVE: begin
                    if (i_ctx_saved) begin
                        state   <= ST_RUN;
                        elapsed <= '0;
                        if (take) begin
                            o_int_id <= i_next;
                        end
                        // else resume the same source
                    end
                end

                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign o_int_active = (state != ST_IDLE);
    assign o_ctx_save   = (state == ST_SAVE);

    // pending filled in at the top
    assign o_status = '{
        active:   o_int_active,
        ctx_save: o_ctx_save,
        cur_id:   o_int_id,
        pending:  '0,
        spare:    '0
    };

endmodule

`default_nettype wire

// File: src/timeslice_icmu_top.sv
`timescale 1ns/1ns
`default_nettype none

module timeslice_icmu_top #(
    parameter int SYNC_STAGES = 2
) (
    input  wire                         i_clk,
    input  wire                         i_rst_n,
    input  wire icmu_pkg::irq_vec_t     i_irq,
    input  wire                         i_tick_1ms,
    input  wire                         i_ctx_saved,
    input  wire                         i_int_done,
    input  wire icmu_pkg::axil_wr_req_t i_wr_req,
    input  wire icmu_pkg::axil_rd_req_t i_rd_req,
    output icmu_pkg::axil_wr_rsp_t      o_wr_rsp,
    output icmu_pkg::axil_rd_rsp_t      o_rd_rsp,
    output icmu_pkg::irq_id_t           o_int_id,
    output logic                        o_int_active,
    output logic                        o_ctx_save
);
    import icmu_pkg::*;

    irq_vec_t      pending;
    irq_vec_t      enable;
    irq_vec_t      clear;
    irq_id_t       next_id;
    logic          next_valid;
    slice_table_t  slices;
    sched_status_t sched_status;
    sched_status_t reg_status;

    assign reg_status = '{
        active:   sched_status.active,
        ctx_save: sched_status.ctx_save,
        cur_id:   sched_status.cur_id,
        pending:  pending,
        spare:    sched_status.spare
    };

    icmu_axil_regs u_regs (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_wr_req (i_wr_req),
        .i_rd_req (i_rd_req),
        .i_status (reg_status),
        .o_wr_rsp (o_wr_rsp),
        .o_rd_rsp (o_rd_rsp),
        .o_slices (slices),
        .o_enable (enable)
    );

    irq_capture #(
        .SYNC_STAGES (SYNC_STAGES)
    ) u_capture (
        .i_clk     (i_clk),
        .i_rst_n   (i_rst_n),
        .i_irq     (i_irq),
        .i_enable  (enable),
        .i_clear   (clear),
        .o_pending (pending)
    );

    rr_arbiter u_arbiter (
        .i_pending (pending),
        .i_current (o_int_id),
        .o_next    (next_id),
        .o_valid   (next_valid)
    );

    slice_scheduler u_sched (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_tick_1ms   (i_tick_1ms),
        .i_slices     (slices),
        .i_next       (next_id),
        .i_next_valid (next_valid),
        .i_ctx_saved  (i_ctx_saved),
        .i_int_done   (i_int_done),
        .o_clear      (clear),
        .o_int_id     (o_int_id),
        .o_int_active (o_int_active),
        .o_ctx_save   (o_ctx_save),
        .o_status     (sched_status)
    );

endmodule

`default_nettype wire

// File: sim/icmu_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module icmu_asserts (
    input wire                         i_clk,
    input wire                         i_rst_n,
    input wire icmu_pkg::irq_id_t      i_int_id,
    input wire                         i_int_active,
    input wire                         i_ctx_save,
    input wire                         i_ctx_saved,
    input wire icmu_pkg::axil_wr_req_t i_wr_req,
    input wire icmu_pkg::axil_wr_rsp_t i_wr_rsp,
    input wire icmu_pkg::axil_rd_req_t i_rd_req,
    input wire icmu_pkg::axil_rd_rsp_t i_rd_rsp
);
    import icmu_pkg::*;

    int unsigned fail_count = 0;

    // save and service both held until the cpu confirms
    a_save_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ctx_save && !i_ctx_saved) |=> (i_ctx_save && i_int_active))
        else begin $error("ctx_save or active dropped before ctx_saved"); fail_count++; end

    // id frozen until the cpu confirms the save
    a_id_frozen: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_ctx_save && !i_ctx_saved) |=> $stable(i_int_id))
        else begin $error("int_id moved during context save"); fail_count++; end

    a_bvalid_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_wr_rsp.bvalid && !i_wr_req.bready) |=> i_wr_rsp.bvalid)
        else begin $error("bvalid dropped before bready"); fail_count++; end

    a_rvalid_held: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (i_rd_rsp.rvalid && !i_rd_req.rready) |=> i_rd_rsp.rvalid)
        else begin $error("rvalid dropped before rready"); fail_count++; end

endmodule

bind timeslice_icmu_top icmu_asserts u_asserts (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_int_id (o_int_id), .i_int_active (o_int_active),
    .i_ctx_save (o_ctx_save), .i_ctx_saved (i_ctx_saved), .i_wr_req (i_wr_req),
    .i_wr_rsp (o_wr_rsp), .i_rd_req (i_rd_req), .i_rd_rsp (o_rd_rsp)
);

`default_nettype wire

// File: sim/tb_icmu.sv
`timescale 1ns/1ns
`default_nettype none

module tb_icmu;
    import icmu_pkg::*;

    localparam int SYNC_STAGES = 2;
    localparam int WATCHDOG_NS = 200_000;   // sum of test lengths plus margin

    logic         clk;
    logic         rst_n;
    irq_vec_t     irq;
    logic         tick;
    logic         ctx_saved;
    logic         int_done;
    axil_wr_req_t wr_req;
    axil_rd_req_t rd_req;
    axil_wr_rsp_t wr_rsp;
    axil_rd_rsp_t rd_rsp;
    irq_id_t      int_id;
    logic         int_active;
    logic         ctx_save;
    int           errors = 0;
    int           tests  = 0;
    logic [31:0]  seed   = 32'h5d76_2f05;
    irq_id_t      last_id;

    timeslice_icmu_top #(.SYNC_STAGES(SYNC_STAGES)) u_dut (
        .i_clk (clk), .i_rst_n (rst_n), .i_irq (irq), .i_tick_1ms (tick),
        .i_ctx_saved (ctx_saved), .i_int_done (int_done), .i_wr_req (wr_req),
        .i_rd_req (rd_req), .o_wr_rsp (wr_rsp), .o_rd_rsp (rd_rsp),
        .o_int_id (int_id), .o_int_active (int_active), .o_ctx_save (ctx_save)
    );

    always #5 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic report_error(input string msg);
        $display("[ERROR] %0t ns: %s", $time, msg);
        errors++;
    endtask

    task automatic end_test(input string name, input int start_errors);
        tests++;
        $display("%0t ns: %s finished with %0d errors", $time, name, errors - start_errors);
    endtask

    task automatic axi_write(input logic [7:0] addr, input logic [31:0] data,
                             output logic [1:0] resp);
        int n;
        wr_req = '{awaddr: addr, awvalid: 1'b1, wdata: data, wstrb: '1, wvalid: 1'b1,
                   bready: 1'b0};
        n = 0;
        while (!wr_rsp.awready && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (wr_rsp.wready !== 1'b1) report_error("wready not raised with awready");
        @(negedge clk);   // the edge in between takes the beat
        wr_req.awvalid = 1'b0;
        wr_req.wvalid  = 1'b0;
        if (!wr_rsp.bvalid) begin
            $display("write to 0x%02h waited too long for its response", addr);
            errors++;
        end else begin
            @(negedge clk);   // held while bready is low
            if (!wr_rsp.bvalid) report_error("bvalid dropped before bready");
        end
        resp = wr_rsp.bresp;
        wr_req.bready = 1'b1;
        @(negedge clk);
        wr_req.bready = 1'b0;
    endtask

    task automatic axi_read(input logic [7:0] addr, output logic [31:0] data,
                            output logic [1:0] resp);
        int n;
        rd_req = '{araddr: addr, arvalid: 1'b1, rready: 1'b0};
        n = 0;
        while (!rd_rsp.arready && n < 20) begin
            @(negedge clk);
            n++;
        end
        @(negedge clk);
        rd_req.arvalid = 1'b0;
        if (!rd_rsp.rvalid) begin
            $display("read of 0x%02h waited too long for its response", addr);
            errors++;
        end else begin
            @(negedge clk);   // held while rready is low
            if (!rd_rsp.rvalid) report_error("rvalid dropped before rready");
        end
        data = rd_rsp.rdata;
        resp = rd_rsp.rresp;
        rd_req.rready = 1'b1;
        @(negedge clk);
        rd_req.rready = 1'b0;
    endtask

    task automatic pulse_irq(input irq_vec_t mask);
        irq = mask;
        @(negedge clk);
        irq = '0;
    endtask

    task automatic pulse_tick();
        tick = 1'b1;
        @(negedge clk);
        tick = 1'b0;
    endtask

    task automatic ack_save();
        ctx_saved = 1'b1;
        @(negedge clk);
        ctx_saved = 1'b0;
    endtask

    task automatic wait_active();
        int n;
        n = 0;
        while (!int_active && n < 50) begin
            @(negedge clk);
            n++;
        end
        if (!int_active) begin
            $display("waited too long for o_int_active at %0t ns", $time);
            errors++;
        end
    endtask

    task automatic finish_service();
        int_done = 1'b1;
        @(negedge clk);
        int_done = 1'b0;
        if (int_active) report_error("o_int_active still high after i_int_done");
    endtask

    task automatic serve_expect(input irq_id_t id);
        wait_active();
        if (int_id !== id) report_error($sformatf("served id %0d, expected %0d", int_id, id));
        last_id = id;
        finish_service();
    endtask

    // ticks up to slice expiry with the exact tick checked
    task automatic expire_after(input int n);
        for (int t = 1; t <= n; t++) begin
            pulse_tick();
            if ((t < n) && ctx_save) report_error($sformatf("ctx_save early at tick %0d", t));
            if ((t == n) && !ctx_save) report_error($sformatf("no ctx_save after %0d ticks", n));
        end
    endtask

    task automatic test_register_access();
        slice_t      defaults [NUM_IRQ] = '{8'd10, 8'd20, 8'd5, 8'd15, 8'd30, 8'd25, 8'd40, 8'd50};
        logic [31:0] data;
        logic [1:0]  resp;
        int          start;
        start = errors;
        for (int i = 0; i < NUM_IRQ; i++) begin
            axi_read(8'(i * 4), data, resp);
            if (data !== 32'(defaults[i]) || resp !== 2'b00)
                report_error($sformatf("slice %0d reads 0x%0h resp %0d", i, data, resp));
        end
        axi_read(8'h20, data, resp);
        if (data !== 32'h0000_00ff) report_error($sformatf("enable reads 0x%0h", data));
        axi_write(8'h18, 32'h77, resp);
        axi_read(8'h18, data, resp);
        if (data !== 32'h77) report_error($sformatf("slice 6 reads back 0x%0h", data));
        axi_read(8'h40, data, resp);
        if (resp !== 2'b10) report_error("read of 0x40 not answered with SLVERR");
        axi_write(8'h40, 32'h1, resp);
        if (resp !== 2'b10) report_error("write to 0x40 not answered with SLVERR");
        axi_write(8'h24, 32'hffff, resp);
        if (resp !== 2'b00) report_error("write to status not answered OKAY");
        axi_read(8'h24, data, resp);
        if (data !== 32'h0) report_error($sformatf("status changed to 0x%0h", data));
        axi_write(8'h18, 32'd40, resp);
        end_test("register access", start);
    endtask

    task automatic test_single_dispatch();
        logic [31:0]   data;
        logic [1:0]    resp;
        sched_status_t st;
        int            cnt;
        int            start;
        start = errors;
        irq = 8'h20;
        cnt = 0;
        do begin
            @(negedge clk);
            irq = '0;
            cnt++;
        end while (!int_active && cnt < 20);
        // first edge only samples the line
        if (cnt - 1 != SYNC_STAGES + 2) report_error($sformatf("dispatch latency %0d", cnt - 1));
        if (int_id !== 3'd5) report_error($sformatf("dispatched id %0d, expected 5", int_id));
        finish_service();
        axi_read(8'h24, data, resp);
        st = sched_status_t'(data[15:0]);
        if (st.active || st.pending !== '0) report_error("status not idle after done");
        last_id = 3'd5;
        end_test("single dispatch", start);
    endtask

    task automatic test_round_robin();
        irq_vec_t mask;
        irq_id_t  cur;
        irq_id_t  id;
        int       start;
        start = errors;
        pulse_irq(8'h10);
        wait_active();
        if (int_id !== 3'd4) report_error($sformatf("served id %0d, expected 4", int_id));
        pulse_irq(8'h52);   // 1, 4 and 6 while 4 is running
        repeat (6) @(negedge clk);
        finish_service();
        serve_expect(3'd6);
        serve_expect(3'd1);
        serve_expect(3'd4);
        for (int r = 0; r < 3; r++) begin
            seed = xorshift32(seed);
            mask = seed[7:0];
            if (mask == '0) mask = 8'h81;
            pulse_irq(mask);
            repeat (6) @(negedge clk);
            cur = last_id;
            for (int k = 1; k <= NUM_IRQ; k++) begin
                id = cur + irq_id_t'(k);
                if (mask[id]) serve_expect(id);
            end
        end
        end_test("round robin", start);
    endtask

    task automatic test_slice_expiry();
        logic [1:0] resp;
        int         start;
        start = errors;
        axi_write(8'h0c, 32'd4, resp);
        pulse_irq(8'h08);
        wait_active();
        expire_after(4);
        repeat (5) @(negedge clk);
        finish_service_ignored();
        if (!ctx_save || int_id !== 3'd3) report_error("ctx_save not held for source 3");
        ack_save();
        if (ctx_save || !int_active || int_id !== 3'd3) report_error("source 3 did not resume");
        expire_after(4);
        ack_save();
        finish_service();
        axi_write(8'h0c, 32'd0, resp);
        pulse_irq(8'h08);
        wait_active();
        for (int t = 0; t < 100; t++) begin
            pulse_tick();
            if (ctx_save) report_error($sformatf("zero slice expired at tick %0d", t + 1));
        end
        finish_service();
        end_test("slice expiry", start);
    endtask

    // done while saving must be ignored
    task automatic finish_service_ignored();
        int_done = 1'b1;
        @(negedge clk);
        int_done = 1'b0;
        if (!int_active) report_error("i_int_done ended service during save");
    endtask

    task automatic test_preemption();
        logic [1:0] resp;
        int         start;
        start = errors;
        axi_write(8'h08, 32'd3, resp);
        pulse_irq(8'h04);
        wait_active();
        expire_after(3);
        pulse_irq(8'h80);
        repeat (6) @(negedge clk);
        if (int_id !== 3'd2) report_error("id changed before save was confirmed");
        ack_save();
        if (int_id !== 3'd7 || ctx_save) report_error($sformatf("after save id is %0d", int_id));
        finish_service();
        repeat (10) @(negedge clk);
        if (int_active) report_error("preempted source 2 was served again");
        end_test("preemption switch", start);
    endtask

    task automatic test_masking();
        logic [31:0]   data;
        logic [1:0]    resp;
        sched_status_t st;
        int            start;
        start = errors;
        axi_write(8'h20, 32'hfe, resp);
        pulse_irq(8'h01);
        repeat (8) @(negedge clk);
        axi_read(8'h24, data, resp);
        st = sched_status_t'(data[15:0]);
        if (st.pending[0] || int_active) report_error("masked source 0 got through");
        axi_write(8'h20, 32'hff, resp);
        pulse_irq(8'h02);
        wait_active();
        pulse_irq(8'h01);
        repeat (6) @(negedge clk);
        axi_read(8'h24, data, resp);
        st = sched_status_t'(data[15:0]);
        if (!st.pending[0]) report_error("source 0 not pending while 1 is served");
        axi_write(8'h20, 32'hfe, resp);
        finish_service();
        serve_expect(3'd0);
        axi_write(8'h20, 32'hff, resp);
        end_test("masking", start);
    endtask

    initial begin
        #WATCHDOG_NS;
        $display("watchdog expired, the run took too long");
        $display("*** TEST FAILED ***");
        $finish;
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        irq       = '0;
        tick      = 1'b0;
        ctx_saved = 1'b0;
        int_done  = 1'b0;
        wr_req    = '0;
        rd_req    = '0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        if (int_active || ctx_save || int_id !== '0) report_error("bad outputs after reset");
        if (wr_rsp.awready || wr_rsp.wready || wr_rsp.bvalid || rd_rsp.arready || rd_rsp.rvalid)
            report_error("AXI handshake outputs not low after reset");
        test_register_access();
        test_single_dispatch();
        test_round_robin();
        test_slice_expiry();
        test_preemption();
        test_masking();
        errors += int'(u_dut.u_asserts.fail_count);
        $display("tests run: %0d, errors: %0d", tests, errors);
        if (errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
src/icmu_pkg.sv
src/icmu_axil_regs.sv
src/irq_capture.sv
src/rr_arbiter.sv
src/slice_scheduler.sv
src/timeslice_icmu_top.sv
sim/icmu_asserts.sv
sim/tb_icmu.sv
